// File: src/cmo_pkg.sv
// ==========================================================================
// Fixed geometry of the data cache seen by the CMO handler: 8 sets, 4 ways,
// 64-byte lines, 32-bit byte addresses. Widths below must stay consistent
// ==========================================================================

package cmo_pkg;

    localparam int ADDR_WIDTH       = 32;
    localparam int CL_OFFSET_WIDTH  = 6;
    localparam int NUM_SETS         = 8;
    localparam int SET_WIDTH        = 3;
    localparam int NUM_WAYS         = 4;
    localparam int TAG_WIDTH        = 23;
    localparam int NLINE_WIDTH      = 26;
    localparam int FLUSH_FIFO_DEPTH = 3;

    typedef logic [ADDR_WIDTH-1:0]  addr_t;
    typedef logic [SET_WIDTH-1:0]   set_t;
    typedef logic [TAG_WIDTH-1:0]   tag_t;
    typedef logic [NLINE_WIDTH-1:0] nline_t;
    typedef logic [NUM_WAYS-1:0]    way_vec_t;

    typedef enum logic [2:0] {
        CMO_FENCE,
        CMO_INVAL_NLINE,
        CMO_INVAL_ALL,
        CMO_FLUSH_ALL,
        CMO_FLUSH_INVAL_ALL
    } cmo_op_e;

    typedef struct packed {
        cmo_op_e op;
        addr_t   addr;
    } cmo_req_t;

    // Emptiness levels of the cache blocks the handler waits on
    typedef struct packed {
        logic wbuf_empty;
        logic mshr_empty;
        logic rtab_empty;
        logic ctrl_empty;
    } cmo_quiet_t;

    typedef struct packed {
        cmo_op_e op;
        set_t    set;
        tag_t    tag;
    } cmo_job_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } dir_entry_t;

    // Line number is {tag, set}
    typedef struct packed {
        nline_t   nline;
        way_vec_t way;
    } flush_req_t;

endpackage

// File: src/cmo_req_intake.sv
// ==========================================================================
// Accepts one CMO request at a time. Fences complete here; any other op is
// held until the cache is fully quiet, then handed to the walker as a job
// ==========================================================================

`timescale 1ns/1ps

module cmo_req_intake (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 req_valid_i,
    input  cmo_pkg::cmo_req_t    req_i,
    input  cmo_pkg::cmo_quiet_t  quiet_i,
    input  logic                 walk_busy_i,
    output logic                 req_ready_o,
    output logic                 req_wait_o,
    output logic                 wbuf_flush_all_o,
    output logic                 job_start_o,
    output cmo_pkg::cmo_job_t    job_o
);

    typedef enum logic [1:0] {
        IDLE,
        FENCE_WAIT,
        QUIET_WAIT
    } state_e;

    state_e            state_q, state_d;
    logic              start_q, start_d;
    cmo_pkg::cmo_job_t job_q;
    cmo_pkg::nline_t   req_nline;
    logic              accept;
    logic              is_fence;
    logic              fence_done;
    logic              all_quiet;

    // No new request while a job start is in flight to the walker
    assign req_ready_o = (state_q == IDLE) & ~walk_busy_i & ~start_q;
    assign req_wait_o  = (state_q != IDLE);
    assign accept      = req_valid_i & req_ready_o;
    assign is_fence    = (req_i.op == cmo_pkg::CMO_FENCE);

    assign fence_done = quiet_i.wbuf_empty & quiet_i.rtab_empty;
    assign all_quiet  = quiet_i.wbuf_empty & quiet_i.mshr_empty &
                        quiet_i.rtab_empty & quiet_i.ctrl_empty;

    // Ask the write buffer to send its open entries once replays are done
    assign wbuf_flush_all_o = quiet_i.rtab_empty &
                              ((state_q == FENCE_WAIT) | (accept & is_fence));

    assign req_nline   = req_i.addr[cmo_pkg::CL_OFFSET_WIDTH +: cmo_pkg::NLINE_WIDTH];
    assign job_start_o = start_q;
    assign job_o       = job_q;

    always_comb begin
        state_d = state_q;
        start_d = 1'b0;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    if (is_fence) begin
                        if (!fence_done) begin
                            state_d = FENCE_WAIT;
                        end
                    end else if (all_quiet) begin
                        start_d = 1'b1;
                    end else begin
                        state_d = QUIET_WAIT;
                    end
                end
            end
            FENCE_WAIT: begin
                if (fence_done) begin
                    state_d = IDLE;
                end
            end
            QUIET_WAIT: begin
                if (all_quiet) begin
                    start_d = 1'b1;
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            start_q <= 1'b0;
        end else begin
            state_q <= state_d;
            start_q <= start_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept && !is_fence) begin
            job_q.op  <= req_i.op;
            job_q.set <= req_nline[cmo_pkg::SET_WIDTH-1:0];
            job_q.tag <= req_nline[cmo_pkg::NLINE_WIDTH-1:cmo_pkg::SET_WIDTH];
        end
    end

endmodule

// File: src/cmo_dir_walker.sv
// ==========================================================================
// Runs invalidations and full-cache flush walks on the directory. Directory
// responses arrive one cycle after each check and are never re-requested
// ==========================================================================

`timescale 1ns/1ps

module cmo_dir_walker (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  job_start_i,
    input  cmo_pkg::cmo_job_t     job_i,
    input  logic                  flush_empty_i,
    input  logic                  push_ok_i,
    input  logic                  queue_empty_i,
    output logic                  walk_busy_o,
    output logic                  dir_check_nline_o,
    output cmo_pkg::set_t         dir_check_set_o,
    output cmo_pkg::tag_t         dir_check_tag_o,
    input  cmo_pkg::way_vec_t     dir_hit_way_i,
    output logic                  dir_check_entry_o,
    output cmo_pkg::way_vec_t     dir_entry_way_o,
    input  cmo_pkg::dir_entry_t   dir_entry_i,
    output logic                  dir_inval_o,
    output cmo_pkg::set_t         dir_inval_set_o,
    output cmo_pkg::way_vec_t     dir_inval_way_o,
    output logic                  push_o,
    output cmo_pkg::flush_req_t   push_req_o
);

    typedef enum logic [2:0] {
        IDLE,
        CHECK_NLINE,
        INVAL,
        FLUSH_WALK,
        FLUSH_DRAIN
    } state_e;

    state_e              state_q, state_d;
    cmo_pkg::cmo_job_t   job_q;
    cmo_pkg::set_t       set_q, set_d;
    cmo_pkg::way_vec_t   way_q, way_d;
    logic                inval_q, inval_d;
    logic                pend_valid_q, pend_valid_d;
    cmo_pkg::set_t       pend_set_q;
    cmo_pkg::way_vec_t   pend_way_q;
    logic                hold_valid_q;
    cmo_pkg::flush_req_t hold_q;
    cmo_pkg::flush_req_t resp_req;
    logic                set_last, way_last;
    logic                resp_push, stall, issue;

    assign set_last    = (set_q == cmo_pkg::set_t'(cmo_pkg::NUM_SETS - 1));
    assign way_last    = way_q[cmo_pkg::NUM_WAYS-1];
    assign walk_busy_o = (state_q != IDLE);

    assign dir_check_set_o = (state_q == CHECK_NLINE) ? job_q.set : set_q;
    assign dir_check_tag_o = job_q.tag;
    assign dir_entry_way_o = way_q;

    // Response to the entry checked in the previous cycle
    assign resp_push = pend_valid_q & dir_entry_i.valid & dir_entry_i.dirty;
    assign resp_req  = '{nline: {dir_entry_i.tag, pend_set_q}, way: pend_way_q};

    // A full queue parks the response in the hold register and stops the walk
    assign stall      = (hold_valid_q | resp_push) & ~push_ok_i;
    assign push_o     = (hold_valid_q | resp_push) & push_ok_i;
    assign push_req_o = hold_valid_q ? hold_q : resp_req;

    // With invalidation each entry takes a check cycle and an inval cycle
    assign issue = (state_q == FLUSH_WALK) & ~stall & ~(inval_q & pend_valid_q);

    always_comb begin
        state_d           = state_q;
        set_d             = set_q;
        way_d             = way_q;
        inval_d           = inval_q;
        pend_valid_d      = 1'b0;
        dir_check_nline_o = 1'b0;
        dir_check_entry_o = 1'b0;
        dir_inval_o       = 1'b0;
        dir_inval_set_o   = set_q;
        dir_inval_way_o   = '0;
        case (state_q)
            IDLE: begin
                if (job_start_i) begin
                    set_d   = '0;
                    way_d   = cmo_pkg::way_vec_t'(1);
                    inval_d = (job_i.op == cmo_pkg::CMO_FLUSH_INVAL_ALL);
                    case (job_i.op)
                        cmo_pkg::CMO_INVAL_NLINE:     state_d = CHECK_NLINE;
                        cmo_pkg::CMO_INVAL_ALL:       state_d = INVAL;
                        cmo_pkg::CMO_FLUSH_ALL,
                        cmo_pkg::CMO_FLUSH_INVAL_ALL: state_d = FLUSH_WALK;
                        default:                      state_d = IDLE;
                    endcase
                end
            end
            CHECK_NLINE: begin
                dir_check_nline_o = 1'b1;
                state_d           = INVAL;
            end
            INVAL: begin
                if (job_q.op == cmo_pkg::CMO_INVAL_NLINE) begin
                    // Hit way of the line check comes back this cycle
                    dir_inval_o     = |dir_hit_way_i;
                    dir_inval_set_o = job_q.set;
                    dir_inval_way_o = dir_hit_way_i;
                    state_d         = IDLE;
                end else begin
                    dir_inval_o     = 1'b1;
                    dir_inval_way_o = '1;
                    set_d           = set_q + 1'b1;
                    if (set_last) begin
                        state_d = IDLE;
                    end
                end
            end
            FLUSH_WALK, FLUSH_DRAIN: begin
                dir_inval_o     = inval_q & pend_valid_q;
                dir_inval_set_o = pend_set_q;
                dir_inval_way_o = pend_way_q;
                if (issue) begin
                    dir_check_entry_o = 1'b1;
                    pend_valid_d      = 1'b1;
                    way_d             = {way_q[cmo_pkg::NUM_WAYS-2:0], way_last};
                    if (way_last) begin
                        set_d = set_q + 1'b1;
                    end
                    if (set_last && way_last) begin
                        state_d = FLUSH_DRAIN;
                    end
                end
                // Done once every flush request has left the handler
                if (state_q == FLUSH_DRAIN && !pend_valid_q && !hold_valid_q &&
                    queue_empty_i && flush_empty_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= IDLE;
            set_q        <= '0;
            way_q        <= cmo_pkg::way_vec_t'(1);
            inval_q      <= 1'b0;
            pend_valid_q <= 1'b0;
            hold_valid_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            set_q        <= set_d;
            way_q        <= way_d;
            inval_q      <= inval_d;
            pend_valid_q <= pend_valid_d;
            hold_valid_q <= stall;
        end
    end

    always_ff @(posedge clk_i) begin
        if (job_start_i && state_q == IDLE) begin
            job_q <= job_i;
        end
        if (issue) begin
            pend_set_q <= set_q;
            pend_way_q <= way_q;
        end
        if (stall && !hold_valid_q) begin
            hold_q <= resp_req;
        end
    end

endmodule

// File: src/cmo_flush_fifo.sv
// ==========================================================================
// Small flush request queue with feedthrough: a push into the empty queue is
// visible at the output in the same cycle. Pushing while full is not allowed
// ==========================================================================

`timescale 1ns/1ps

module cmo_flush_fifo (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 push_i,
    input  cmo_pkg::flush_req_t  push_req_i,
    output logic                 push_ok_o,
    output logic                 empty_o,
    output logic                 flush_alloc_o,
    input  logic                 flush_alloc_ready_i,
    output cmo_pkg::flush_req_t  flush_alloc_req_o
);

    typedef logic [$clog2(cmo_pkg::FLUSH_FIFO_DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(cmo_pkg::FLUSH_FIFO_DEPTH+1)-1:0] cnt_t;

    cmo_pkg::flush_req_t mem_q [cmo_pkg::FLUSH_FIFO_DEPTH];
    ptr_t                rptr_q, wptr_q;
    cnt_t                count_q;
    logic                empty, pop, write, read;

    function automatic ptr_t next_ptr(input ptr_t ptr);
        return (ptr == ptr_t'(cmo_pkg::FLUSH_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty     = (count_q == '0);
    assign empty_o   = empty;
    assign push_ok_o = (count_q != cnt_t'(cmo_pkg::FLUSH_FIFO_DEPTH));

    assign flush_alloc_o     = ~empty | push_i;
    assign flush_alloc_req_o = empty ? push_req_i : mem_q[rptr_q];
    assign pop               = flush_alloc_o & flush_alloc_ready_i;

    // A pushed entry popped in the same cycle never enters the buffer
    assign write = push_i & ~(empty & pop);
    assign read  = pop & ~empty;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rptr_q  <= '0;
            wptr_q  <= '0;
            count_q <= '0;
        end else begin
            if (write) begin
                wptr_q <= next_ptr(wptr_q);
            end
            if (read) begin
                rptr_q <= next_ptr(rptr_q);
            end
            case ({write, read})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (write) begin
            mem_q[wptr_q] <= push_req_i;
        end
    end

endmodule

// File: src/cmo_handler.sv
// ==========================================================================
// CMO handler top: one operation at a time, request intake, directory walk
// and flush queue. Directory answers checks exactly one cycle later
// ==========================================================================

`timescale 1ns/1ps

module cmo_handler (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // Request port
    input  logic                  req_valid_i,
    input  cmo_pkg::cmo_req_t     req_i,
    output logic                  req_ready_o,
    output logic                  req_wait_o,
    // Cache status and write buffer
    input  cmo_pkg::cmo_quiet_t   quiet_i,
    output logic                  wbuf_flush_all_o,
    input  logic                  flush_empty_i,
    // Directory
    output logic                  dir_check_nline_o,
    output cmo_pkg::set_t         dir_check_set_o,
    output cmo_pkg::tag_t         dir_check_tag_o,
    input  cmo_pkg::way_vec_t     dir_hit_way_i,
    output logic                  dir_check_entry_o,
    output cmo_pkg::way_vec_t     dir_entry_way_o,
    input  cmo_pkg::dir_entry_t   dir_entry_i,
    output logic                  dir_inval_o,
    output cmo_pkg::set_t         dir_inval_set_o,
    output cmo_pkg::way_vec_t     dir_inval_way_o,
    // Flush controller
    output logic                  flush_alloc_o,
    input  logic                  flush_alloc_ready_i,
    output cmo_pkg::flush_req_t   flush_alloc_req_o
);

    logic                walk_busy;
    logic                job_start;
    cmo_pkg::cmo_job_t   job;
    logic                push;
    cmo_pkg::flush_req_t push_req;
    logic                push_ok;
    logic                queue_empty;

    cmo_req_intake cmo_req_intake_inst (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .req_valid_i      (req_valid_i),
        .req_i            (req_i),
        .quiet_i          (quiet_i),
        .walk_busy_i      (walk_busy),
        .req_ready_o      (req_ready_o),
        .req_wait_o       (req_wait_o),
        .wbuf_flush_all_o (wbuf_flush_all_o),
        .job_start_o      (job_start),
        .job_o            (job)
    );

    cmo_dir_walker cmo_dir_walker_inst (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .job_start_i       (job_start),
        .job_i             (job),
        .flush_empty_i     (flush_empty_i),
        .push_ok_i         (push_ok),
        .queue_empty_i     (queue_empty),
        .walk_busy_o       (walk_busy),
        .dir_check_nline_o (dir_check_nline_o),
        .dir_check_set_o   (dir_check_set_o),
        .dir_check_tag_o   (dir_check_tag_o),
        .dir_hit_way_i     (dir_hit_way_i),
        .dir_check_entry_o (dir_check_entry_o),
        .dir_entry_way_o   (dir_entry_way_o),
        .dir_entry_i       (dir_entry_i),
        .dir_inval_o       (dir_inval_o),
        .dir_inval_set_o   (dir_inval_set_o),
        .dir_inval_way_o   (dir_inval_way_o),
        .push_o            (push),
        .push_req_o        (push_req)
    );

    cmo_flush_fifo cmo_flush_fifo_inst (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .push_i              (push),
        .push_req_i          (push_req),
        .push_ok_o           (push_ok),
        .empty_o             (queue_empty),
        .flush_alloc_o       (flush_alloc_o),
        .flush_alloc_ready_i (flush_alloc_ready_i),
        .flush_alloc_req_o   (flush_alloc_req_o)
    );

endmodule

// File: test/cmo_handler_chk.sv
// ==========================================================================
// Port rules of the CMO handler, bound into every instance of it
// ==========================================================================

`timescale 1ns/1ps

module cmo_handler_chk (
    input logic                 clk_i,
    input logic                 rst_ni,
    input logic                 req_valid_i,
    input cmo_pkg::cmo_req_t    req_i,
    input logic                 req_ready_o,
    input logic                 req_wait_o,
    input logic                 dir_inval_o,
    input cmo_pkg::way_vec_t    dir_inval_way_o,
    input logic                 flush_alloc_o,
    input logic                 flush_alloc_ready_i,
    input cmo_pkg::flush_req_t  flush_alloc_req_o
);

    a_req_op_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_valid_i |-> req_i.op inside {cmo_pkg::CMO_FENCE, cmo_pkg::CMO_INVAL_NLINE,
            cmo_pkg::CMO_INVAL_ALL, cmo_pkg::CMO_FLUSH_ALL, cmo_pkg::CMO_FLUSH_INVAL_ALL})
        else $error("request carries an unknown CMO opcode");

    // An offered flush request waits unchanged for the flush controller
    a_alloc_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_alloc_o && !flush_alloc_ready_i |=> flush_alloc_o && $stable(flush_alloc_req_o))
        else $error("flush request changed before it was taken");

    a_inval_way: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dir_inval_o |-> dir_inval_way_o != '0)
        else $error("invalidation strobe without any way selected");

    a_ready_wait: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_wait_o |-> !req_ready_o)
        else $error("ready is high while the handler waits");

endmodule

bind cmo_handler cmo_handler_chk cmo_handler_chk_inst (.*);

// File: test/tb_cmo_handler.sv
// ==========================================================================
// Directed testbench for the CMO handler. The directory model answers each
// check one cycle later, and the flush side is ready at random when enabled
// ==========================================================================

`timescale 1ns/1ps

module tb_cmo_handler;

    logic                 clk_i;
    logic                 rst_ni;
    logic                 req_valid_i;
    cmo_pkg::cmo_req_t    req_i;
    logic                 req_ready_o;
    logic                 req_wait_o;
    cmo_pkg::cmo_quiet_t  quiet_i;
    logic                 wbuf_flush_all_o;
    logic                 flush_empty_i;
    logic                 dir_check_nline_o;
    cmo_pkg::set_t        dir_check_set_o;
    cmo_pkg::tag_t        dir_check_tag_o;
    cmo_pkg::way_vec_t    dir_hit_way_i;
    logic                 dir_check_entry_o;
    cmo_pkg::way_vec_t    dir_entry_way_o;
    cmo_pkg::dir_entry_t  dir_entry_i;
    logic                 dir_inval_o;
    cmo_pkg::set_t        dir_inval_set_o;
    cmo_pkg::way_vec_t    dir_inval_way_o;
    logic                 flush_alloc_o;
    logic                 flush_alloc_ready_i;
    cmo_pkg::flush_req_t  flush_alloc_req_o;

    // Directory model and monitor state
    cmo_pkg::dir_entry_t  dir_mem [cmo_pkg::NUM_SETS][cmo_pkg::NUM_WAYS];
    logic                 nline_pend;
    logic                 entry_pend;
    cmo_pkg::set_t        pend_set;
    cmo_pkg::tag_t        pend_tag;
    cmo_pkg::way_vec_t    pend_way;
    logic [6:0]           inval_q [$];
    cmo_pkg::flush_req_t  popped_q [$];
    logic                 rand_ready;
    logic                 ready_pat [256];
    logic [7:0]           cyc;

    cmo_handler cmo_handler_inst (.*);

    always #10 clk_i = ~clk_i;

    task automatic abort(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            abort($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    function automatic int way_index(input cmo_pkg::way_vec_t way);
        int idx;
        idx = 0;
        for (int w = 0; w < cmo_pkg::NUM_WAYS; w++) begin
            if (way[w]) begin
                idx = w;
            end
        end
        return idx;
    endfunction

    // Monitor: record strobes and pops, apply invalidations to the model
    always @(negedge clk_i) begin
        if (dir_inval_o) begin
            inval_q.push_back({dir_inval_set_o, dir_inval_way_o});
            for (int w = 0; w < cmo_pkg::NUM_WAYS; w++) begin
                if (dir_inval_way_o[w]) begin
                    dir_mem[dir_inval_set_o][w].valid = 1'b0;
                end
            end
        end
        if (flush_alloc_o && flush_alloc_ready_i) begin
            popped_q.push_back(flush_alloc_req_o);
        end
        nline_pend = dir_check_nline_o;
        entry_pend = dir_check_entry_o;
        pend_set   = dir_check_set_o;
        pend_tag   = dir_check_tag_o;
        pend_way   = dir_entry_way_o;
    end

    // Directory answers and flush-side ready, driven just after the edge
    always @(posedge clk_i) begin
        #2;
        dir_hit_way_i = '0;
        dir_entry_i   = '0;
        if (nline_pend) begin
            for (int w = 0; w < cmo_pkg::NUM_WAYS; w++) begin
                if (dir_mem[pend_set][w].valid && dir_mem[pend_set][w].tag == pend_tag) begin
                    dir_hit_way_i[w] = 1'b1;
                end
            end
        end
        if (entry_pend) begin
            dir_entry_i = dir_mem[pend_set][way_index(pend_way)];
        end
        flush_alloc_ready_i = rand_ready ? ready_pat[cyc] : 1'b1;
        cyc = cyc + 8'd1;
    end

    task automatic next_cycle();
        @(posedge clk_i);
        #2;
    endtask

    task automatic clear_monitor();
        inval_q.delete();
        popped_q.delete();
    endtask

    task automatic fill_dir();
        for (int s = 0; s < cmo_pkg::NUM_SETS; s++) begin
            for (int w = 0; w < cmo_pkg::NUM_WAYS; w++) begin
                dir_mem[s][w].valid = ($urandom_range(0, 3) != 0);
                dir_mem[s][w].dirty = $urandom_range(0, 1);
                dir_mem[s][w].tag   = cmo_pkg::tag_t'($urandom);
            end
        end
    endtask

    // Hold valid until the handler takes the request
    task automatic issue_req(input cmo_pkg::cmo_op_e op, input cmo_pkg::addr_t addr);
        int n;
        n = 0;
        req_valid_i = 1'b1;
        req_i       = '{op: op, addr: addr};
        @(negedge clk_i);
        while (!req_ready_o) begin
            n++;
            if (n > 200) begin
                abort("timeout: request was never accepted");
            end
            @(negedge clk_i);
        end
        next_cycle();
        req_valid_i = 1'b0;
    endtask

    task automatic wait_ready(input string what);
        int n;
        n = 0;
        @(negedge clk_i);
        while (!req_ready_o) begin
            n++;
            if (n > 1000) begin
                abort({"timeout: handler never finished ", what});
            end
            @(negedge clk_i);
        end
        next_cycle();
    endtask

    task automatic fence_drain();
        int hold;
        hold = 3 + $urandom_range(0, 5);
        // Empty write buffer completes at once
        issue_req(cmo_pkg::CMO_FENCE, '0);
        @(negedge clk_i);
        compare("req_ready_o", req_ready_o, 1);
        compare("req_wait_o", req_wait_o, 0);
        next_cycle();
        quiet_i.wbuf_empty = 1'b0;
        issue_req(cmo_pkg::CMO_FENCE, '0);
        for (int i = 0; i < hold; i++) begin
            @(negedge clk_i);
            compare("req_wait_o", req_wait_o, 1);
            compare("wbuf_flush_all_o", wbuf_flush_all_o, 1);
            compare("req_ready_o", req_ready_o, 0);
        end
        next_cycle();
        quiet_i.wbuf_empty = 1'b1;
        wait_ready("a fence");
    endtask

    task automatic inval_by_line();
        cmo_pkg::set_t s;
        cmo_pkg::tag_t t;
        int            w;
        fill_dir();
        s = cmo_pkg::set_t'($urandom);
        t = cmo_pkg::tag_t'($urandom);
        w = $urandom_range(0, cmo_pkg::NUM_WAYS - 1);
        for (int i = 0; i < cmo_pkg::NUM_WAYS; i++) begin
            dir_mem[s][i].tag = t ^ cmo_pkg::tag_t'(1);
        end
        dir_mem[s][w] = '{valid: 1'b1, dirty: 1'b0, tag: t};
        clear_monitor();
        issue_req(cmo_pkg::CMO_INVAL_NLINE, {t, s, 6'h15});
        wait_ready("invalidate-by-line");
        compare("inval count", inval_q.size(), 1);
        compare("dir_inval_set_o", inval_q[0][6:4], s);
        compare("dir_inval_way_o", inval_q[0][3:0], 4'b1 << w);
        // Same line again now misses
        clear_monitor();
        issue_req(cmo_pkg::CMO_INVAL_NLINE, {t, s, 6'h00});
        wait_ready("invalidate-by-line miss");
        compare("inval count", inval_q.size(), 0);
    endtask

    task automatic inval_all_sets();
        fill_dir();
        clear_monitor();
        issue_req(cmo_pkg::CMO_INVAL_ALL, '0);
        wait_ready("invalidate-all");
        compare("inval count", inval_q.size(), cmo_pkg::NUM_SETS);
        for (int i = 0; i < cmo_pkg::NUM_SETS; i++) begin
            compare("dir_inval_set_o", inval_q[i][6:4], i);
            compare("dir_inval_way_o", inval_q[i][3:0], 4'hf);
        end
    endtask

    task automatic flush_walk(input logic with_inval);
        cmo_pkg::flush_req_t exp_q [$];
        fill_dir();
        for (int s = 0; s < cmo_pkg::NUM_SETS; s++) begin
            for (int w = 0; w < cmo_pkg::NUM_WAYS; w++) begin
                if (dir_mem[s][w].valid && dir_mem[s][w].dirty) begin
                    exp_q.push_back('{nline: {dir_mem[s][w].tag, cmo_pkg::set_t'(s)},
                                      way: cmo_pkg::way_vec_t'(1 << w)});
                end
            end
        end
        clear_monitor();
        rand_ready = 1'b1;
        issue_req(with_inval ? cmo_pkg::CMO_FLUSH_INVAL_ALL : cmo_pkg::CMO_FLUSH_ALL, '0);
        wait_ready("a flush walk");
        rand_ready = 1'b0;
        compare("flush count", popped_q.size(), exp_q.size());
        for (int i = 0; i < exp_q.size(); i++) begin
            compare("flush_alloc_req_o", popped_q[i], exp_q[i]);
        end
        if (with_inval) begin
            for (int s = 0; s < cmo_pkg::NUM_SETS; s++) begin
                for (int w = 0; w < cmo_pkg::NUM_WAYS; w++) begin
                    compare("model valid", dir_mem[s][w].valid, 0);
                end
            end
        end else begin
            compare("inval count", inval_q.size(), 0);
        end
    endtask

    task automatic quiet_gate();
        int hold;
        hold = 4 + $urandom_range(0, 4);
        fill_dir();
        clear_monitor();
        quiet_i.mshr_empty = 1'b0;
        issue_req(cmo_pkg::CMO_INVAL_ALL, '0);
        for (int i = 0; i < hold; i++) begin
            @(negedge clk_i);
            compare("req_wait_o", req_wait_o, 1);
            compare("dir_inval_o", dir_inval_o, 0);
            compare("dir_check_nline_o", dir_check_nline_o, 0);
            compare("dir_check_entry_o", dir_check_entry_o, 0);
        end
        next_cycle();
        quiet_i.mshr_empty = 1'b1;
        wait_ready("invalidate-all after quiescence");
        compare("inval count", inval_q.size(), cmo_pkg::NUM_SETS);
    endtask

    initial begin
        #2_000_000;
        abort("timeout: simulation ran far too long");
    end

    initial begin
        void'($urandom(20200));
        for (int i = 0; i < 256; i++) begin
            ready_pat[i] = ($urandom_range(0, 3) == 0);
        end
        clk_i               = 1'b0;
        rst_ni              = 1'b0;
        req_valid_i         = 1'b0;
        req_i               = '0;
        quiet_i             = '1;
        flush_empty_i       = 1'b1;
        dir_hit_way_i       = '0;
        dir_entry_i         = '0;
        flush_alloc_ready_i = 1'b1;
        rand_ready          = 1'b0;
        nline_pend          = 1'b0;
        entry_pend          = 1'b0;
        cyc                 = '0;
        fill_dir();
        @(negedge clk_i);
        compare("req_ready_o", req_ready_o, 1);
        compare("req_wait_o", req_wait_o, 0);
        compare("wbuf_flush_all_o", wbuf_flush_all_o, 0);
        compare("dir_check_nline_o", dir_check_nline_o, 0);
        compare("dir_check_entry_o", dir_check_entry_o, 0);
        compare("dir_inval_o", dir_inval_o, 0);
        compare("flush_alloc_o", flush_alloc_o, 0);
        next_cycle();
        rst_ni = 1'b1;
        fence_drain();
        inval_by_line();
        inval_all_sets();
        flush_walk(1'b0);
        flush_walk(1'b1);
        quiet_gate();
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: all.f
src/cmo_pkg.sv
src/cmo_req_intake.sv
src/cmo_dir_walker.sv
src/cmo_flush_fifo.sv
src/cmo_handler.sv
test/cmo_handler_chk.sv
test/tb_cmo_handler.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the CMO handler testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_cmo_handler -f all.f
./obj_dir/Vtb_cmo_handler > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log || ! grep -q "TB PASSED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
